// File: verilog/game_state_pkg.sv
/*
 * game flow types
 * state machine encoding, stage index and life count
 */

package game_state_pkg;

    localparam int STAGE_W = 3; // up to 8 stages
    localparam int LIVES_W = 3; // up to 7 lives

    // top level game flow states
    typedef enum logic [2:0] {
        IDLE      = 3'd0, // waiting for start
        RUN       = 3'd1, // stage in progress
        PAUSE     = 3'd2, // frozen by pause switch
        STAGE_WON = 3'd3, // one cycle between stages
        GAME_WON  = 3'd4, // last stage cleared
        GAME_OVER = 3'd5  // no lives left
    } game_state_t;

    // stage index, 0 is the first stage
    typedef logic [STAGE_W-1:0] stage_t;

    // remaining player lives
    typedef logic [LIVES_W-1:0] lives_t;

endpackage

// File: verilog/enemy_pkg.sv
/*
 * enemy group definitions
 * mask bit positions, enemy mask and kill count types
 */

package enemy_pkg;

    localparam int NUM_ENEMY = 3; // monsters, asteroids, boss
    localparam int KILL_W    = 6; // kill count width

    // bit positions inside an enemy mask
    localparam int ENEMY_MONST  = 0;
    localparam int ENEMY_ASTERO = 1;
    localparam int ENEMY_BOSS   = 2;

    // one bit per enemy group
    typedef logic [NUM_ENEMY-1:0] enemy_mask_t;

    // kill count and kill target of a stage
    typedef logic [KILL_W-1:0] kill_count_t;

endpackage

// File: verilog/switch_sync.sv
/*
 * input synchronizers for the board switches
 * start and pause two-flop sync, skip button edge pulse
 */
`timescale 1ns/1ps

module switch_sync (
    input  logic clk,
    input  logic resetN,
    input  logic start_game,
    input  logic pause,
    input  logic skip_stage,
    output logic start_sync,
    output logic pause_sync,
    output logic skip_pulse
);

    logic start_meta; // first sync stage
    logic pause_meta;
    logic skip_meta;
    logic skip_sync;  // also the previous skip sample

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            start_meta <= 1'b0;
            start_sync <= 1'b0;
            pause_meta <= 1'b0;
            pause_sync <= 1'b0;
            skip_meta  <= 1'b0;
            skip_sync  <= 1'b0;
        end else begin
            start_meta <= start_game;
            start_sync <= start_meta;
            pause_meta <= pause;
            pause_sync <= pause_meta;
            skip_meta  <= skip_stage;
            skip_sync  <= skip_meta;
        end
    end

    assign skip_pulse = skip_meta & ~skip_sync; // one pulse per press

endmodule

// File: verilog/stage_controller.sv
/*
 * stage sequencer
 * stage index register, enemy mix and kill target per stage,
 * last stage flag
 */
`timescale 1ns/1ps

module stage_controller
    import game_state_pkg::*, enemy_pkg::*;
#(
    parameter int NUM_STAGES = 3,
    parameter int KILL_BASE  = 4
) (
    input  logic        clk,
    input  logic        resetN,
    input  logic        stage_restart,
    input  logic        stage_advance,
    output stage_t      stage_num,
    output logic        last_stage,
    output enemy_mask_t enemy_mix,
    output kill_count_t kill_target
);

    localparam stage_t LAST_STAGE = stage_t'(NUM_STAGES - 1);

    logic first_stage;

    // stage index, restart wins over advance
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            stage_num <= '0;
        end else if (stage_restart) begin
            stage_num <= '0;
        end else if (stage_advance && !last_stage) begin
            stage_num <= stage_num + 1'b1; // saturates at last stage
        end
    end

    assign last_stage  = (stage_num == LAST_STAGE);
    assign first_stage = (stage_num == '0);

    // which enemy groups play in this stage
    always_comb begin
        enemy_mix               = '0;
        enemy_mix[ENEMY_MONST]  = !last_stage;  // all but the last
        enemy_mix[ENEMY_ASTERO] = !first_stage; // from stage 1 on
        enemy_mix[ENEMY_BOSS]   = last_stage;   // boss fight at the end
    end

    // kills needed grow with the stage index
    assign kill_target = kill_count_t'(KILL_BASE * (int'(stage_num) + 1));

endmodule

// File: verilog/kill_counter.sv
/*
 * enemy kill counter
 * counts hits in run, clears per stage, flags stage cleared
 */
`timescale 1ns/1ps

module kill_counter
    import enemy_pkg::*;
(
    input  logic        clk,
    input  logic        resetN,
    input  logic        stage_restart,
    input  logic        stage_advance,
    input  logic        counting,
    input  logic        enemy_hit,
    input  kill_count_t kill_target,
    output logic        stage_cleared
);

    kill_count_t kill_count;

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            kill_count <= '0;
        end else if (stage_restart || stage_advance) begin
            kill_count <= '0; // new game or next stage
        end else if (counting && enemy_hit && !stage_cleared) begin
            kill_count <= kill_count + 1'b1; // holds at target
        end
    end

    assign stage_cleared = (kill_count == kill_target);

endmodule

// File: verilog/life_counter.sv
/*
 * player life counter
 * loads the start lives, decrements on hits, player dead flag
 */
`timescale 1ns/1ps

module life_counter
    import game_state_pkg::*;
#(
    parameter int NUM_LIVES = 3
) (
    input  logic   clk,
    input  logic   resetN,
    input  logic   stage_restart,
    input  logic   counting,
    input  logic   player_hit,
    output lives_t lives,
    output logic   player_dead
);

    localparam lives_t START_LIVES = lives_t'(NUM_LIVES);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            lives <= START_LIVES;
        end else if (stage_restart) begin
            lives <= START_LIVES; // reloaded while idle
        end else if (counting && player_hit && !player_dead) begin
            lives <= lives - 1'b1; // stops at zero
        end
    end

    assign player_dead = (lives == '0);

endmodule

// File: verilog/game_controller.sv
/*
 * game flow FSM
 * idle, run, pause, stage won, game won and game over,
 * player and enemy group enable and reset outputs
 */
`timescale 1ns/1ps

module game_controller
    import game_state_pkg::*, enemy_pkg::*;
(
    input  logic        clk,
    input  logic        resetN,
    input  logic        start_sync,
    input  logic        pause_sync,
    input  logic        skip_pulse,
    input  logic        stage_cleared,
    input  logic        player_dead,
    input  logic        last_stage,
    input  enemy_mask_t enemy_mix,
    output logic        stage_restart,
    output logic        stage_advance,
    output logic        counting,
    output logic        enable_player,
    output logic        resetN_player,
    output enemy_mask_t enemy_enable,
    output enemy_mask_t enemy_resetN,
    output logic        game_over,
    output logic        game_won
);

    game_state_t state;
    game_state_t next_state;
    logic        game_ended; // won or lost, waiting for start to drop

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (start_sync) next_state = RUN;
            end
            RUN: begin
                if (!start_sync)                      next_state = IDLE;
                else if (pause_sync)                  next_state = PAUSE;
                else if (player_dead)                 next_state = GAME_OVER;
                else if (stage_cleared || skip_pulse) next_state = STAGE_WON;
            end
            PAUSE: begin
                if (!start_sync)      next_state = IDLE; // quitting beats resume
                else if (!pause_sync) next_state = RUN;
            end
            STAGE_WON: begin
                // always a single cycle
                next_state = last_stage ? GAME_WON : RUN;
            end
            GAME_WON, GAME_OVER: begin
                if (!start_sync) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // Moore outputs, decoded from the registered state only
    assign game_over     = (state == GAME_OVER);
    assign game_won      = (state == GAME_WON);
    assign game_ended    = game_over | game_won;

    assign stage_restart = (state == IDLE);
    assign stage_advance = (state == STAGE_WON); // one cycle pulse
    assign counting      = (state == RUN);

    assign enable_player = counting;
    assign resetN_player = !(stage_restart || game_ended);

    // enemy groups move only in run, and stay in reset when not in the mix
    assign enemy_enable  = counting ? enemy_mix : '0;
    assign enemy_resetN  = (stage_restart || stage_advance || game_ended) ? '0 : enemy_mix;

endmodule

// File: verilog/game_top.sv
/*
 * top level of the game flow control
 * connects sync, FSM, stage sequencer, kill and life counters
 */
`timescale 1ns/1ps

module game_top
    import game_state_pkg::*, enemy_pkg::*;
#(
    parameter int NUM_STAGES = 3,
    parameter int NUM_LIVES  = 3,
    parameter int KILL_BASE  = 4
) (
    input  logic        clk,
    input  logic        resetN,
    input  logic        start_game,    // level switch
    input  logic        pause,         // level switch
    input  logic        skip_stage,    // push button
    input  logic        enemy_hit,     // one cycle pulse
    input  logic        player_hit,    // one cycle pulse
    output stage_t      stage_num,
    output lives_t      lives,
    output logic        game_over,
    output logic        game_won,
    output logic        enable_player,
    output logic        resetN_player,
    output enemy_mask_t enemy_enable,
    output enemy_mask_t enemy_resetN
);

    logic        start_sync;
    logic        pause_sync;
    logic        skip_pulse;
    logic        stage_restart;
    logic        stage_advance;
    logic        counting;
    logic        last_stage;
    logic        stage_cleared;
    logic        player_dead;
    enemy_mask_t enemy_mix;
    kill_count_t kill_target;

    switch_sync i_switch_sync (
        .clk        (clk),
        .resetN     (resetN),
        .start_game (start_game),
        .pause      (pause),
        .skip_stage (skip_stage),
        .start_sync (start_sync),
        .pause_sync (pause_sync),
        .skip_pulse (skip_pulse)
    );

    stage_controller #(
        .NUM_STAGES (NUM_STAGES),
        .KILL_BASE  (KILL_BASE)
    ) i_stage_controller (
        .clk           (clk),
        .resetN        (resetN),
        .stage_restart (stage_restart),
        .stage_advance (stage_advance),
        .stage_num     (stage_num),
        .last_stage    (last_stage),
        .enemy_mix     (enemy_mix),
        .kill_target   (kill_target)
    );

    kill_counter i_kill_counter (
        .clk           (clk),
        .resetN        (resetN),
        .stage_restart (stage_restart),
        .stage_advance (stage_advance),
        .counting      (counting),
        .enemy_hit     (enemy_hit),
        .kill_target   (kill_target),
        .stage_cleared (stage_cleared)
    );

    life_counter #(
        .NUM_LIVES (NUM_LIVES)
    ) i_life_counter (
        .clk           (clk),
        .resetN        (resetN),
        .stage_restart (stage_restart),
        .counting      (counting),
        .player_hit    (player_hit),
        .lives         (lives),
        .player_dead   (player_dead)
    );

    game_controller i_game_controller (
        .clk           (clk),
        .resetN        (resetN),
        .start_sync    (start_sync),
        .pause_sync    (pause_sync),
        .skip_pulse    (skip_pulse),
        .stage_cleared (stage_cleared),
        .player_dead   (player_dead),
        .last_stage    (last_stage),
        .enemy_mix     (enemy_mix),
        .stage_restart (stage_restart),
        .stage_advance (stage_advance),
        .counting      (counting),
        .enable_player (enable_player),
        .resetN_player (resetN_player),
        .enemy_enable  (enemy_enable),
        .enemy_resetN  (enemy_resetN),
        .game_over     (game_over),
        .game_won      (game_won)
    );

endmodule

// File: testbench/game_props.sv
/*
 * concurrent checks on the game_top outputs
 */
`timescale 1ns/1ps

module game_props
    import game_state_pkg::*, enemy_pkg::*;
#(
    parameter int NUM_STAGES = 3
) (
    input logic        clk,
    input logic        resetN,
    input stage_t      stage_num,
    input logic        game_over,
    input logic        game_won,
    input logic        enable_player,
    input enemy_mask_t enemy_enable,
    input enemy_mask_t enemy_resetN
);

    int prop_errors = 0; // failed assertions so far

    end_states_exclusive: assert property (
        @(posedge clk) disable iff (!resetN) !(game_won && game_over)
    ) else begin
        $error("game_won and game_over are high together");
        prop_errors++;
    end

    // an enabled group must be out of reset
    enable_needs_reset_release: assert property (
        @(posedge clk) disable iff (!resetN) (enemy_enable & ~enemy_resetN) == '0
    ) else begin
        $error("enemy group enabled while held in reset");
        prop_errors++;
    end

    stage_in_range: assert property (
        @(posedge clk) disable iff (!resetN) int'(stage_num) < NUM_STAGES
    ) else begin
        $error("stage_num beyond the last stage");
        prop_errors++;
    end

    player_stopped_when_over: assert property (
        @(posedge clk) disable iff (!resetN) game_over |-> !enable_player
    ) else begin
        $error("player enabled after game over");
        prop_errors++;
    end

endmodule

// File: testbench/game_tb.sv
/*
 * testbench for game_top
 * reads the command script, drives the DUT and checks its outputs
 */
`timescale 1ns/1ps

module game_tb
    import game_state_pkg::*, enemy_pkg::*;
();

    localparam int NUM_STAGES = 3;
    localparam int NUM_LIVES  = 3;
    localparam int KILL_BASE  = 4;

    logic        clk;
    logic        resetN;
    logic        start_game;
    logic        pause;
    logic        skip_stage;
    logic        enemy_hit;
    logic        player_hit;
    stage_t      stage_num;
    lives_t      lives;
    logic        game_over;
    logic        game_won;
    logic        enable_player;
    logic        resetN_player;
    enemy_mask_t enemy_enable;
    enemy_mask_t enemy_resetN;

    string cmd_word[$]; // script commands in file order
    int    cmd_arg[$];
    int    errors;
    int    cycles;
    int    timeout_limit;

    game_top i_dut (.*);

    bind game_top game_props #(
        .NUM_STAGES (NUM_STAGES)
    ) i_game_props (
        .clk           (clk),
        .resetN        (resetN),
        .stage_num     (stage_num),
        .game_over     (game_over),
        .game_won      (game_won),
        .enable_player (enable_player),
        .enemy_enable  (enemy_enable),
        .enemy_resetN  (enemy_resetN)
    );

    always #5 clk = ~clk;

    task automatic next_cycle();
        @(posedge clk);
        #1; // drive and sample just after the edge
    endtask

    task automatic send_hits(input bit to_player, input int count);
        repeat (count) begin
            if (to_player) begin
                player_hit = 1'b1;
            end else begin
                enemy_hit = 1'b1;
            end
            next_cycle();
            player_hit = 1'b0;
            enemy_hit  = 1'b0;
            next_cycle(); // idle cycle between pulses
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (actual == expected)
        else begin
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    // everything stopped and held in reset while idle
    task automatic check_idle_outputs();
        check_value("enable_player", 0, int'(enable_player));
        check_value("resetN_player", 0, int'(resetN_player));
        check_value("enemy_enable", 0, int'(enemy_enable));
        check_value("enemy_resetN", 0, int'(enemy_resetN));
        check_value("game_over", 0, int'(game_over));
        check_value("game_won", 0, int'(game_won));
    endtask

    // player and enemy groups held in reset once the game has ended
    task automatic check_ended_outputs();
        check_value("resetN_player", 0, int'(resetN_player));
        check_value("enemy_resetN", 0, int'(enemy_resetN));
    endtask

    // clock cycles of one command, -1 if the command is unknown
    function automatic int command_cycles(input string word, input int arg);
        if (word == "wait") return arg;
        if (word == "skip") return arg + 4;
        if (word == "enemy_hit" || word == "player_hit") return 2 * arg + 4;
        if (word == "start" || word == "pause") return 4;
        if (word == "check_stage" || word == "check_lives" || word == "check_enemy") return 4;
        if (word == "check_over" || word == "check_won" || word == "check_player") return 4;
        return -1;
    endfunction

    task automatic read_script();
        int    fd;
        int    fields;
        int    arg;
        int    cost;
        string line;
        string word;
        fd = $fopen("testbench/game_input.txt", "r");
        if (fd == 0) begin
            $display("cannot open the command script testbench/game_input.txt");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%s %d", word, arg);
            if (fields < 1 || word.substr(0, 0) == "#") continue; // blank or comment
            cost = command_cycles(word, arg);
            if (fields != 2 || cost < 0) begin
                $display("bad line in the command script: %s", line);
                errors++;
            end else begin
                cmd_word.push_back(word);
                cmd_arg.push_back(arg);
                timeout_limit += cost;
            end
        end
        $fclose(fd);
    endtask

    task automatic run_command(input string word, input int arg);
        if (word == "wait") begin
            repeat (arg) next_cycle();
        end else begin
            if (word == "start") begin
                start_game = (arg != 0);
            end else if (word == "pause") begin
                pause = (arg != 0);
            end else if (word == "skip") begin
                skip_stage = 1'b1;
                repeat (arg) next_cycle(); // button held down
                skip_stage = 1'b0;
            end else if (word == "enemy_hit") begin
                send_hits(1'b0, arg);
            end else if (word == "player_hit") begin
                send_hits(1'b1, arg);
            end else if (word == "check_stage") begin
                check_value("stage_num", arg, int'(stage_num));
            end else if (word == "check_lives") begin
                check_value("lives", arg, int'(lives));
            end else if (word == "check_enemy") begin
                check_value("enemy_enable", arg, int'(enemy_enable));
                if (arg != 0) begin
                    check_value("enemy_resetN", arg, int'(enemy_resetN)); // groups in play
                end
            end else if (word == "check_over") begin
                check_value("game_over", arg, int'(game_over));
                if (arg != 0) begin
                    check_ended_outputs();
                end
            end else if (word == "check_won") begin
                check_value("game_won", arg, int'(game_won));
                if (arg != 0) begin
                    check_ended_outputs();
                end
            end else begin
                check_value("enable_player", arg, int'(enable_player));
                if (arg != 0) begin
                    check_value("resetN_player", 1, int'(resetN_player)); // running
                end
            end
            repeat (4) next_cycle(); // covers 2 sync stages and the state register
        end
    endtask

    initial begin
        clk           = 1'b0;
        resetN        = 1'b0;
        start_game    = 1'b0;
        pause         = 1'b0;
        skip_stage    = 1'b0;
        enemy_hit     = 1'b0;
        player_hit    = 1'b0;
        errors        = 0;
        cycles        = 0;
        timeout_limit = 50; // margin on top of the script length
        $display("game_tb: %0d stages, %0d lives, kill base %0d",
                 NUM_STAGES, NUM_LIVES, KILL_BASE);
        read_script();
        repeat (3) @(posedge clk);
        #1;
        resetN = 1'b1;
        check_idle_outputs();
        foreach (cmd_word[i]) run_command(cmd_word[i], cmd_arg[i]);
        errors = errors + i_dut.i_game_props.prop_errors;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("timeout: script did not finish");
            errors = errors + 1;
            $display("errors: %0d", errors);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

// File: testbench/game_input.txt
# columns: command, value in decimal
# checks give the expected value, enemy mask bit 0 monsters, bit 1 asteroids, bit 2 boss
check_stage 0
check_lives 3
check_enemy 0
check_over 0
start 1
check_enemy 1
check_player 1
enemy_hit 4
check_stage 1
check_enemy 3
pause 1
check_enemy 0
enemy_hit 5
pause 0
enemy_hit 7
check_stage 1
skip 1
check_stage 2
check_enemy 6
enemy_hit 12
check_won 1
check_enemy 0
check_over 0
start 0
check_won 0
check_stage 0
check_lives 3
start 1
player_hit 1
check_lives 2
player_hit 2
check_over 1
check_player 0
check_lives 0
start 0
start 1
skip 10
check_stage 1
pause 1
skip 1
pause 0
check_stage 1
check_enemy 3

// File: all.f
verilog/game_state_pkg.sv
verilog/enemy_pkg.sv
verilog/switch_sync.sv
verilog/stage_controller.sv
verilog/kill_counter.sv
verilog/life_counter.sv
verilog/game_controller.sv
verilog/game_top.sv
testbench/game_props.sv
testbench/game_tb.sv

// File: Makefile
# Verilator build and run of the game flow testbench
VERILATOR ?= verilator
TOP       ?= game_tb
FLAGS     ?= --binary --assert --timing -Wno-fatal

.PHONY: sim clean

# the run passes only when the pass message shows up in its output
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
